/* source/ipv4_rewrite_settings.svh */
//################################################
// pipeline depth is fixed by the RTL stage count
// RW_EXPIRE_TTL must stay within 0 to 255
//################################################

`ifndef IPV4_REWRITE_SETTINGS_SVH
`define IPV4_REWRITE_SETTINGS_SVH

// cycles from a sampled request to its result strobe
// one field edit stage plus two checksum update stages
`define RW_PIPE_DEPTH 3

// incoming TTL at or below this value marks the packet for drop
// a router may not forward a packet whose TTL reaches zero,
// so the default drops anything arriving with TTL 1 or 0
`define RW_EXPIRE_TTL 1

`endif

/* source/ipv4_rewrite_pkg.sv */
//################################################
// types shared by the IPv4 header rewrite pipeline
// header words are in network order, bits 15:8 first
//################################################

`default_nettype none

package ipv4_rewrite_pkg;

    // one's-complement header checksum, as carried in header word 5
    typedef logic [15:0] csum_t;

    // one 16-bit word of the IPv4 header
    typedef logic [15:0] hword_t;

    // sideband carried beside the TTL checksum update
    typedef struct packed {
        hword_t tos_old;  // word 0 as received
        hword_t tos_new;  // word 0 after DSCP remark
        hword_t ttl_new;  // word 4 after TTL decrement
        logic   expired;  // TTL at or below the drop threshold
    } edit_side_t;

    // sideband carried beside the TOS checksum update
    // the old TOS word is consumed by that stage, so it is not kept
    typedef struct packed {
        hword_t ttl_new;
        hword_t tos_new;
        logic   expired;
    } final_side_t;

    // 16-bit one's-complement add with end-around carry
    function automatic csum_t add1c(input csum_t a, input csum_t b);
        logic [16:0] sum;
        sum = {1'b0, a} + {1'b0, b};
        // folding the carry back in cannot overflow a second time
        return sum[15:0] + {15'd0, sum[16]};
    endfunction

endpackage

`default_nettype wire

/* source/ipv4_field_edit.sv */
//################################################
// TTL decrement saturates at 0; protocol byte passes
// one request per cycle, no stall, 1 cycle latency
//################################################

`default_nettype none

`include "ipv4_rewrite_settings.svh"

module ipv4_field_edit (
    input  logic                         clk,
    input  logic                         rst_n_i,
    input  logic                         req_i,
    input  ipv4_rewrite_pkg::csum_t      old_csum_i,
    input  ipv4_rewrite_pkg::hword_t     tos_word_i,
    input  ipv4_rewrite_pkg::hword_t     ttl_word_i,
    input  logic                         remark_en_i,
    input  logic [5:0]                   dscp_i,
    output logic                         valid_o,
    output ipv4_rewrite_pkg::csum_t      csum_o,
    output ipv4_rewrite_pkg::hword_t     ttl_old_o,
    output ipv4_rewrite_pkg::hword_t     ttl_new_o,
    output ipv4_rewrite_pkg::edit_side_t side_o
);

    import ipv4_rewrite_pkg::*;

    logic [7:0] ttl_in;        // TTL byte of the incoming word 4
    logic [7:0] ttl_dec;
    logic       expired;
    hword_t     ttl_word_new;
    hword_t     tos_word_new;

    logic       valid_q;
    csum_t      csum_q;
    hword_t     ttl_old_q;
    hword_t     ttl_new_q;
    edit_side_t side_q;

    assign ttl_in = ttl_word_i[15:8];

    always_comb begin
        // a TTL of 0 should never arrive, but it must not wrap to 255
        if (ttl_in == 8'd0) begin
            ttl_dec = 8'd0;
        end else begin
            ttl_dec = ttl_in - 8'd1;
        end

        expired = (ttl_in <= 8'(`RW_EXPIRE_TTL));

        ttl_word_new = {ttl_dec, ttl_word_i[7:0]};  // protocol byte kept

        // DSCP lives in bits 7:2 of word 0
        // version/IHL above it and ECN below it are never touched
        if (remark_en_i) begin
            tos_word_new = {tos_word_i[15:8], dscp_i, tos_word_i[1:0]};
        end else begin
            tos_word_new = tos_word_i;
        end
    end

    // request strobe
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= req_i;
        end
    end

    // payload only loads on a request
    always_ff @(posedge clk) begin
        if (req_i) begin
            csum_q          <= old_csum_i;
            ttl_old_q       <= ttl_word_i;
            ttl_new_q       <= ttl_word_new;
            side_q.tos_old  <= tos_word_i;
            side_q.tos_new  <= tos_word_new;
            side_q.ttl_new  <= ttl_word_new;
            side_q.expired  <= expired;
        end
    end

    assign valid_o   = valid_q;
    assign csum_o    = csum_q;     // checksum is only repaired downstream
    assign ttl_old_o = ttl_old_q;
    assign ttl_new_o = ttl_new_q;
    assign side_o    = side_q;

endmodule

`default_nettype wire

/* source/ipv4_checksum_update.sv */
//################################################
// RFC 1624 update for one changed word, 1 cycle
// old checksum 0xFFFF is not a legal input value
//################################################

`default_nettype none

module ipv4_checksum_update #(
    parameter type side_t = logic
) (
    input  logic                     clk,
    input  logic                     rst_n_i,
    input  logic                     update_req_i,
    input  ipv4_rewrite_pkg::csum_t  old_csum_i,
    input  ipv4_rewrite_pkg::hword_t old_field_i,
    input  ipv4_rewrite_pkg::hword_t new_field_i,
    input  side_t                    side_i,
    output logic                     update_valid_o,
    output ipv4_rewrite_pkg::csum_t  new_csum_o,
    output side_t                    side_o
);

    import ipv4_rewrite_pkg::*;

    csum_t inv_csum;     // ~HC
    csum_t inv_old;      // ~m
    csum_t partial_sum;  // ~HC + ~m
    csum_t total_sum;    // ~HC + ~m + m'
    csum_t csum_next;

    logic  valid_q;
    csum_t csum_q;
    side_t side_q;

    // HC' = ~(~HC + ~m + m')  (RFC 1624 eqn. 3)
    // each add folds its carry back in before the next one
    assign inv_csum    = ~old_csum_i;
    assign inv_old     = ~old_field_i;
    assign partial_sum = add1c(inv_csum, inv_old);
    assign total_sum   = add1c(partial_sum, new_field_i);
    assign csum_next   = ~total_sum;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= update_req_i;
        end
    end

    // checksum result loads with the request, holds otherwise
    always_ff @(posedge clk) begin
        if (update_req_i) begin
            csum_q <= csum_next;
        end
    end

    // sideband rides along untouched
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            side_q <= '0;
        end else if (update_req_i) begin
            side_q <= side_i;
        end
    end

    assign update_valid_o = valid_q;
    assign new_csum_o     = csum_q;
    assign side_o         = side_q;

endmodule

`default_nettype wire

/* source/ipv4_rewrite_top.sv */
//################################################
// result 3 cycles after each request, in order
// no back-pressure; outputs valid only with the strobe
//################################################

`default_nettype none

module ipv4_rewrite_top (
    input  logic                     clk,
    input  logic                     rst_n_i,
    input  logic                     rewrite_req_i,
    input  ipv4_rewrite_pkg::csum_t  old_csum_i,
    input  ipv4_rewrite_pkg::hword_t tos_word_i,
    input  ipv4_rewrite_pkg::hword_t ttl_word_i,
    input  logic                     remark_en_i,
    input  logic [5:0]               dscp_i,
    output logic                     rewrite_valid_o,
    output ipv4_rewrite_pkg::csum_t  new_csum_o,
    output ipv4_rewrite_pkg::hword_t new_ttl_word_o,
    output ipv4_rewrite_pkg::hword_t new_tos_word_o,
    output logic                     drop_o
);

    import ipv4_rewrite_pkg::*;

    // field edit stage outputs
    logic        edit_valid;
    csum_t       edit_csum;
    hword_t      edit_ttl_old;
    hword_t      edit_ttl_new;
    edit_side_t  edit_side;

    // after the TTL word has been folded into the checksum
    logic        ttl_valid;
    csum_t       ttl_csum;
    edit_side_t  ttl_side;

    final_side_t tos_side_in;
    final_side_t tos_side_out;

    ipv4_field_edit u_field_edit (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .req_i       (rewrite_req_i),
        .old_csum_i  (old_csum_i),
        .tos_word_i  (tos_word_i),
        .ttl_word_i  (ttl_word_i),
        .remark_en_i (remark_en_i),
        .dscp_i      (dscp_i),
        .valid_o     (edit_valid),
        .csum_o      (edit_csum),
        .ttl_old_o   (edit_ttl_old),
        .ttl_new_o   (edit_ttl_new),
        .side_o      (edit_side)
    );

    // word 4 update, TTL always changes
    ipv4_checksum_update #(
        .side_t (edit_side_t)
    ) u_csum_ttl (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .update_req_i   (edit_valid),
        .old_csum_i     (edit_csum),
        .old_field_i    (edit_ttl_old),
        .new_field_i    (edit_ttl_new),
        .side_i         (edit_side),
        .update_valid_o (ttl_valid),
        .new_csum_o     (ttl_csum),
        .side_o         (ttl_side)
    );

    // old TOS word is used up here, the rest moves on
    assign tos_side_in.ttl_new = ttl_side.ttl_new;
    assign tos_side_in.tos_new = ttl_side.tos_new;
    assign tos_side_in.expired = ttl_side.expired;

    // word 0 update, an identity when no remark was asked for
    ipv4_checksum_update #(
        .side_t (final_side_t)
    ) u_csum_tos (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .update_req_i   (ttl_valid),
        .old_csum_i     (ttl_csum),
        .old_field_i    (ttl_side.tos_old),
        .new_field_i    (ttl_side.tos_new),
        .side_i         (tos_side_in),
        .update_valid_o (rewrite_valid_o),
        .new_csum_o     (new_csum_o),
        .side_o         (tos_side_out)
    );

    assign new_ttl_word_o = tos_side_out.ttl_new;
    assign new_tos_word_o = tos_side_out.tos_new;
    assign drop_o         = tos_side_out.expired;

endmodule

`default_nettype wire

/* verification/ipv4_rewrite_clkgen.sv */
//################################################
// 10-unit clock; reset held low for 5 rising edges
//################################################

`default_nettype none

module ipv4_rewrite_clkgen (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (5) @(posedge clk_o);
        @(negedge clk_o);  // release away from the sampling edge
        rst_n_o = 1'b1;
    end

endmodule

`default_nettype wire

/* verification/ipv4_rewrite_sva.sv */
//################################################
// strobe timing checks, bound to ipv4_rewrite_top
// assumes a fixed RW_PIPE_DEPTH with no stalls
//################################################

`default_nettype none

`include "ipv4_rewrite_settings.svh"

module ipv4_rewrite_sva (
    input logic clk,
    input logic rst_n_i,
    input logic req_i,
    input logic valid_i,
    input logic drop_i
);

    localparam int DEPTH = `RW_PIPE_DEPTH;

    // every sampled request yields a result strobe DEPTH edges later
    a_req_to_valid : assert property (@(posedge clk) disable iff (!rst_n_i)
        req_i |-> ##DEPTH valid_i)
        else $error("result strobe missing %0d cycles after a request", DEPTH);

    // a result strobe needs a request DEPTH edges back
    a_valid_has_req : assert property (@(posedge clk) disable iff (!rst_n_i)
        valid_i |-> $past(req_i, DEPTH))
        else $error("result strobe without a matching request");

    // reset clears the strobe and the drop flag
    a_reset_clears : assert property (@(posedge clk)
        !rst_n_i |=> (!valid_i && !drop_i))
        else $error("result strobe or drop flag high after a reset edge");

endmodule

`default_nettype wire

/* verification/ipv4_rewrite_tb.sv */
//################################################
// table of headers issued back to back after reset
// expected results from incremental and full sums
//################################################

`default_nettype none

`include "ipv4_rewrite_settings.svh"

module ipv4_rewrite_tb;

    localparam int N_FIXED     = 8;
    localparam int TAB_LEN     = 32;
    localparam int TIMEOUT_CYC = TAB_LEN + 50;

    // header word i sits at bits 16*(9-i) +: 16
    localparam logic [159:0] KNOWN_HDR = 160'h4500_0073_0000_4000_4011_b861_c0a8_0001_c0a8_00c7;

    typedef struct {
        int          row;
        logic [15:0] csum_inc;   // chained RFC 1624 updates
        logic [15:0] csum_full;  // full sum over the modified header
        logic [15:0] ttl;
        logic [15:0] tos;
        logic        drop;
        int          due;        // cycle count when the strobe is seen
    } exp_t;

    logic        clk;
    logic        rst_n;
    logic        rewrite_req;
    logic [15:0] old_csum;
    logic [15:0] tos_word;
    logic [15:0] ttl_word;
    logic        remark_en;
    logic [5:0]  dscp;
    logic        rewrite_valid;
    logic [15:0] new_csum;
    logic [15:0] new_ttl_word;
    logic [15:0] new_tos_word;
    logic        drop;

    logic [159:0] hdr_tab [TAB_LEN];
    logic         remark_tab [TAB_LEN];
    logic [5:0]   dscp_tab [TAB_LEN];
    exp_t         exp_q [$];

    int cycle_cnt = 0;
    int issue_idx;
    int got_cnt;
    int value_errs;
    int order_errs;
    int other_errs;
    bit timed_out;

    ipv4_rewrite_clkgen u_clkgen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    ipv4_rewrite_top i_ipv4_rewrite_top (
        .clk             (clk),
        .rst_n_i         (rst_n),
        .rewrite_req_i   (rewrite_req),
        .old_csum_i      (old_csum),
        .tos_word_i      (tos_word),
        .ttl_word_i      (ttl_word),
        .remark_en_i     (remark_en),
        .dscp_i          (dscp),
        .rewrite_valid_o (rewrite_valid),
        .new_csum_o      (new_csum),
        .new_ttl_word_o  (new_ttl_word),
        .new_tos_word_o  (new_tos_word),
        .drop_o          (drop)
    );

    bind ipv4_rewrite_top ipv4_rewrite_sva u_sva (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .req_i   (rewrite_req_i),
        .valid_i (rewrite_valid_o),
        .drop_i  (drop_o)
    );

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // 32-bit accumulate, then fold carries until 16 bits remain
    function automatic logic [15:0] fold_sum(input logic [31:0] acc_in);
        logic [31:0] acc;
        acc = acc_in;
        while (acc[31:16] != 16'd0) begin
            acc = {16'd0, acc[15:0]} + {16'd0, acc[31:16]};
        end
        return acc[15:0];
    endfunction

    // checksum over all words but word 5
    function automatic logic [15:0] full_csum(input logic [159:0] hdr);
        logic [31:0] acc;
        acc = 32'd0;
        for (int i = 0; i < 10; i++) begin
            if (i != 5) acc = acc + {16'd0, hdr[16*(9-i) +: 16]};
        end
        return ~fold_sum(acc);
    endfunction

    function automatic logic [15:0] incr_csum(input logic [15:0] hc, input logic [15:0] old_w,
                                              input logic [15:0] new_w);
        logic [31:0] acc;
        acc = {16'd0, ~hc} + {16'd0, ~old_w} + {16'd0, new_w};
        return ~fold_sum(acc);
    endfunction

    task automatic show_mismatch(input string sig, input int row, input logic [15:0] got,
                                 input logic [15:0] exp);
        $display("[ERROR] t=%0t row %0d %s got 0x%04h expected 0x%04h", $time, row, sig, got, exp);
    endtask

    task automatic build_table();
        logic [31:0] rnd;
        logic [7:0]  ttl_b;
        for (int r = 0; r < N_FIXED; r++) begin
            hdr_tab[r]    = KNOWN_HDR;
            remark_tab[r] = 1'b0;
            dscp_tab[r]   = 6'd0;
        end
        hdr_tab[1][95:80] = 16'h0011;  // TTL 0 stays 0
        hdr_tab[2][95:80] = 16'h0111;
        hdr_tab[3][95:80] = 16'h0211;
        hdr_tab[4][95:80] = 16'hff06;
        hdr_tab[5][159:144] = 16'h4503;  // ECN bits set
        remark_tab[5] = 1'b1;
        dscp_tab[5]   = 6'h2e;
        hdr_tab[6][159:144] = 16'h46b9;
        remark_tab[6] = 1'b1;
        dscp_tab[6]   = 6'h00;
        hdr_tab[7][159:144] = 16'h45b8;  // remark to the same DSCP
        remark_tab[7] = 1'b1;
        dscp_tab[7]   = 6'h2e;
        for (int r = N_FIXED; r < TAB_LEN; r++) begin
            rnd = $urandom();
            hdr_tab[r][159:144] = {8'h45, rnd[7:0]};
            hdr_tab[r][143:128] = rnd[31:16];
            remark_tab[r] = rnd[8];
            dscp_tab[r]   = rnd[14:9];
            rnd = $urandom();
            hdr_tab[r][127:96] = rnd;
            rnd = $urandom();
            ttl_b = (rnd[2:0] == 3'd0) ? {5'd0, rnd[5:3]} : rnd[15:8];  // low TTLs now and then
            hdr_tab[r][95:80] = {ttl_b, rnd[23:16]};
            rnd = $urandom();
            hdr_tab[r][63:32] = rnd;
            rnd = $urandom();
            hdr_tab[r][31:0] = rnd;
        end
        for (int r = 0; r < TAB_LEN; r++) begin
            hdr_tab[r][79:64] = full_csum(hdr_tab[r]);
        end
    endtask

    task automatic drive_next();
        logic [159:0] hdr;
        logic [159:0] modded;
        logic [15:0]  w0;
        logic [15:0]  w4;
        logic [15:0]  ttl_new;
        logic [15:0]  tos_new;
        exp_t         e;
        if (issue_idx < TAB_LEN) begin
            hdr = hdr_tab[issue_idx];
            w0  = hdr[159:144];
            w4  = hdr[95:80];
            if (w4[15:8] == 8'd0) ttl_new = w4;
            else ttl_new = {w4[15:8] - 8'd1, w4[7:0]};
            if (remark_tab[issue_idx]) tos_new = {w0[15:8], dscp_tab[issue_idx], w0[1:0]};
            else tos_new = w0;
            modded = hdr;
            modded[159:144] = tos_new;
            modded[95:80]   = ttl_new;
            e.row       = issue_idx;
            e.csum_inc  = incr_csum(incr_csum(hdr[79:64], w4, ttl_new), w0, tos_new);
            e.csum_full = full_csum(modded);
            e.ttl       = ttl_new;
            e.tos       = tos_new;
            e.drop      = (int'(w4[15:8]) <= `RW_EXPIRE_TTL);
            e.due       = cycle_cnt + `RW_PIPE_DEPTH;
            exp_q.push_back(e);
            rewrite_req = 1'b1;
            old_csum    = hdr[79:64];
            tos_word    = w0;
            ttl_word    = w4;
            remark_en   = remark_tab[issue_idx];
            dscp        = dscp_tab[issue_idx];
            issue_idx++;
        end else begin
            rewrite_req = 1'b0;
        end
    endtask

    task automatic check_outputs();
        exp_t e;
        if (rst_n && issue_idx == 0) begin
            if (rewrite_valid !== 1'b0) begin
                value_errs++;
                show_mismatch("rewrite_valid_o", -1, {15'd0, rewrite_valid}, 16'd0);
            end
            if (drop !== 1'b0) begin
                value_errs++;
                show_mismatch("drop_o", -1, {15'd0, drop}, 16'd0);
            end
        end
        if (rewrite_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                other_errs++;
                $display("result strobe at time %0t with no request outstanding", $time);
            end else begin
                e = exp_q.pop_front();
                got_cnt++;
                if (cycle_cnt != e.due) begin
                    order_errs++;
                    $display("row %0d result seen at cycle %0d instead of cycle %0d",
                             e.row, cycle_cnt, e.due);
                end
                if (new_csum !== e.csum_inc) begin
                    value_errs++;
                    show_mismatch("new_csum_o", e.row, new_csum, e.csum_inc);
                end
                if (new_csum !== e.csum_full) begin
                    value_errs++;
                    show_mismatch("new_csum_o (full sum)", e.row, new_csum, e.csum_full);
                end
                if (new_ttl_word !== e.ttl) begin
                    value_errs++;
                    show_mismatch("new_ttl_word_o", e.row, new_ttl_word, e.ttl);
                end
                if (new_tos_word !== e.tos) begin
                    value_errs++;
                    show_mismatch("new_tos_word_o", e.row, new_tos_word, e.tos);
                end
                if (drop !== e.drop) begin
                    value_errs++;
                    show_mismatch("drop_o", e.row, {15'd0, drop}, {15'd0, e.drop});
                end
            end
        end
    endtask

    initial begin
        rewrite_req = 1'b0;
        old_csum    = 16'd0;
        tos_word    = 16'd0;
        ttl_word    = 16'd0;
        remark_en   = 1'b0;
        dscp        = 6'd0;
        issue_idx   = 0;
        got_cnt     = 0;
        value_errs  = 0;
        order_errs  = 0;
        other_errs  = 0;
        timed_out   = 1'b0;
        void'($urandom(22));
        build_table();
        if (hdr_tab[0][79:64] !== 16'hb861) begin
            value_errs++;
            show_mismatch("reference header checksum", 0, hdr_tab[0][79:64], 16'hb861);
        end

        @(posedge rst_n);
        repeat (4) begin  // idle after reset, nothing may come out
            @(negedge clk);
            check_outputs();
        end

        while (got_cnt < TAB_LEN && !timed_out) begin
            @(negedge clk);
            check_outputs();
            drive_next();
            if (cycle_cnt >= TIMEOUT_CYC) timed_out = 1'b1;
        end
        if (!timed_out) begin
            repeat (4) begin  // catch any extra strobe
                @(negedge clk);
                check_outputs();
            end
        end else begin
            other_errs++;
            $display("timeout at cycle %0d with %0d of %0d results received",
                     cycle_cnt, got_cnt, TAB_LEN);
        end

        $display("errors: value %0d, order %0d, other %0d", value_errs, order_errs, other_errs);
        if (value_errs + order_errs + other_errs == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+source
source/ipv4_rewrite_pkg.sv
source/ipv4_field_edit.sv
source/ipv4_checksum_update.sv
source/ipv4_rewrite_top.sv
verification/ipv4_rewrite_clkgen.sv
verification/ipv4_rewrite_sva.sv
verification/ipv4_rewrite_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the IPv4 rewrite testbench with Verilator.
# Exit status is 0 only when the simulation log reports a pass.

set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir

verilator --binary --timing --assert \
    --top-module ipv4_rewrite_tb \
    -f filelist.f \
    2>&1 | tee build.log

./obj_dir/Vipv4_rewrite_tb 2>&1 | tee sim.log

if grep -q "SIMULATION PASSED" sim.log; then
    echo "run_sim: pass"
    exit 0
else
    echo "run_sim: fail, see sim.log"
    exit 1
fi
